// File: logic/mem_pkg.sv
/*
  Shared constants for the power-gated register file subsystem.
  Holds array geometry, power chain delay, the APB register map and
  the power sequencer state codes. Modules take it by wildcard import.
*/
package mem_pkg;

    // ----------------------------------------------------------------------
    // Array geometry
    // ----------------------------------------------------------------------

    localparam int rf_depth  = 64;
    localparam int rf_addr_w = 6;
    // Logical word as seen by the queue manager
    localparam int rf_data_w = 17;
    // Physical array is one bit wider, the spare bit is tied off
    localparam int rf_phys_w = 18;

    // rclk cycles for a power enable change to ripple through the array
    localparam int pwr_chain_dly = 4;

    // ----------------------------------------------------------------------
    // APB register map
    // ----------------------------------------------------------------------

    localparam int apb_addr_w = 8;
    localparam int apb_data_w = 32;

    // Control register, bit 0 requests power on
    localparam logic [apb_addr_w-1:0] reg_pwr_ctrl = 8'h00;
    // Status register, bit 0 chain acknowledge and bit 1 array ready
    localparam logic [apb_addr_w-1:0] reg_pwr_stat = 8'h04;

    // ----------------------------------------------------------------------
    // Power sequencer states
    // ----------------------------------------------------------------------

    localparam logic [1:0] st_off           = 2'd0;
    localparam logic [1:0] st_powering      = 2'd1;
    localparam logic [1:0] st_on            = 2'd2;
    localparam logic [1:0] st_powering_down = 2'd3;

endpackage

// File: logic/mem_pwr_if.sv
/*
  Power management bundle between the power-gate controller and the
  register file wrapper. The controller side drives isolation, power
  enable and array reset; the memory side returns the chain output.
*/
`timescale 1ns/1ps

interface mem_pwr_if;

    // Active high clamp of the array outputs
    logic pgcb_isol_en;
    // Active low power enable into the array daisy chain
    logic pwr_enable_b_in;
    // Same enable after it has rippled through every array segment
    logic pwr_enable_b_out;
    // Active low array reset, still asynchronous to rclk here
    logic ip_reset_b;

    modport ctrl (
        output pgcb_isol_en,
        output pwr_enable_b_in,
        output ip_reset_b,
        input  pwr_enable_b_out
    );

    modport mem (
        input  pgcb_isol_en,
        input  pwr_enable_b_in,
        input  ip_reset_b,
        output pwr_enable_b_out
    );

endinterface

// File: logic/mem_reset_sync_scan.sv
/*
  Reset synchronizer with scan bypass.
  Asserts asynchronously, releases after two clk edges. In scan mode the
  output follows the tester-controlled bypass reset instead.
*/
`timescale 1ns/1ps

module mem_reset_sync_scan (
    input  logic clk,
    input  logic rst_n,
    input  logic fscan_rstbypen,
    input  logic fscan_byprst_b,
    output logic rst_n_sync
);

    logic [1:0] sync_q;

    // A one shifts in behind the released reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q <= 2'b00;
        end else begin
            sync_q <= {sync_q[0], 1'b1};
        end
    end

    // Scan takes the reset away from the functional path entirely
    assign rst_n_sync = fscan_rstbypen ? fscan_byprst_b : sync_q[1];

    // A reset seen low must still be low two edges later in functional mode
    a_hold_through_sync : assert property (@(posedge clk)
        (!rst_n && !fscan_rstbypen) ##1 !fscan_rstbypen ##1 !fscan_rstbypen
        |-> !rst_n_sync)
        else $error("reset released without a full synchronizer cycle");

endmodule

// File: logic/rf_array_64x18.sv
/*
  Behavioral model of the 64x18 two-port power-gated array.
  Write port on wclk, registered read port on rclk, output clamp on
  isolation and a power enable daisy chain clocked by rclk. Contents
  are lost, modelled as zeros, whenever the chain reports power off.
*/
`timescale 1ns/1ps

module rf_array_64x18 import mem_pkg::*; (
    input  logic                 wclk,
    input  logic                 we,
    input  logic [rf_addr_w-1:0] waddr,
    input  logic [rf_phys_w-1:0] wdata,
    input  logic                 rclk,
    input  logic                 re,
    input  logic [rf_addr_w-1:0] raddr,
    output logic [rf_phys_w-1:0] data_out,
    input  logic                 ip_reset_b,
    input  logic                 isolation_in,
    input  logic                 pwr_mgmt_in,
    output logic                 pwr_mgmt_out
);

    logic [rf_phys_w-1:0] mem [rf_depth];
    logic [rf_phys_w-1:0] rd_q;
    // The chain starts in the off state, like silicon before any enable
    logic [pwr_chain_dly-1:0] pwr_chain = '1;

    // ----------------------------------------------------------------------
    // Power enable daisy chain
    // ----------------------------------------------------------------------

    // Each stage stands for one array segment switching its supply
    always_ff @(posedge rclk) begin
        pwr_chain <= {pwr_chain[pwr_chain_dly-2:0], pwr_mgmt_in};
    end

    // High at the last stage means the whole array is unpowered
    assign pwr_mgmt_out = pwr_chain[pwr_chain_dly-1];

    // ----------------------------------------------------------------------
    // Storage and ports
    // ----------------------------------------------------------------------

    // Unpowered cells lose their data, so every word reads back as zero
    always_ff @(posedge wclk) begin
        if (pwr_mgmt_out) begin
            for (int i = 0; i < rf_depth; i++) begin
                mem[i] <= '0;
            end
        end else if (we && ip_reset_b) begin
            mem[waddr] <= wdata;
        end
    end

    // Read latch holds its word until the next enabled read
    // The same-edge write lands after this sample, so the old word is returned
    always_ff @(posedge rclk) begin
        if (pwr_mgmt_out) begin
            rd_q <= '0;
        end else if (re && ip_reset_b) begin
            rd_q <= mem[raddr];
        end
    end

    // Clamp keeps undefined levels off the fabric during power transitions
    assign data_out = isolation_in ? '0 : rd_q;

    // Controller must keep the array isolated until power has settled
    a_no_write_unpowered : assert property (@(posedge wclk)
        !(we && !isolation_in && pwr_mgmt_out))
        else $error("write to unpowered array with isolation released");

endmodule

// File: logic/rf_pg_64x17.sv
/*
  Power-gated 64x17 register file wrapper.
  Widens the logical word onto the 18-bit physical array, brings the
  array reset into the rclk domain and hands the power controls through.
*/
`timescale 1ns/1ps

module rf_pg_64x17 import mem_pkg::*; (
    input  logic                 wclk,
    input  logic                 we,
    input  logic [rf_addr_w-1:0] waddr,
    input  logic [rf_data_w-1:0] wdata,
    input  logic                 rclk,
    input  logic                 re,
    input  logic [rf_addr_w-1:0] raddr,
    output logic [rf_data_w-1:0] rdata,
    mem_pwr_if.mem               pwr,
    input  logic                 fscan_byprst_b,
    // Kept for pin compatibility, the model has no gated clocks to open
    input  logic                 fscan_clkungate,
    input  logic                 fscan_rstbypen
);

    logic [rf_phys_w-1:0] wdata_phys;
    logic [rf_phys_w-1:0] rdata_phys;
    logic                 ip_reset_b_sync;

    // Spare physical bit is written as zero
    assign wdata_phys = {{(rf_phys_w - rf_data_w){1'b0}}, wdata};

    // Array reset is released on rclk so the read latch sees a clean edge
    mem_reset_sync_scan u_ip_reset_sync (
        .clk            (rclk),
        .rst_n          (pwr.ip_reset_b),
        .fscan_rstbypen (fscan_rstbypen),
        .fscan_byprst_b (fscan_byprst_b),
        .rst_n_sync     (ip_reset_b_sync)
    );

    rf_array_64x18 u_rf (
        .wclk         (wclk),
        .we           (we),
        .waddr        (waddr),
        .wdata        (wdata_phys),
        .rclk         (rclk),
        .re           (re),
        .raddr        (raddr),
        .data_out     (rdata_phys),
        .ip_reset_b   (ip_reset_b_sync),
        .isolation_in (pwr.pgcb_isol_en),
        .pwr_mgmt_in  (pwr.pwr_enable_b_in),
        .pwr_mgmt_out (pwr.pwr_enable_b_out)
    );

    // Drop the spare bit on the way out
    assign rdata = rdata_phys[rf_data_w-1:0];

endmodule

// File: logic/pgcb_apb_ctrl.sv
/*
  Power-gate controller with an APB register interface.
  Software sets or clears the power request in the control register and
  polls status. The sequencer orders power enable, isolation and array
  reset around the power chain acknowledge.
*/
`timescale 1ns/1ps

module pgcb_apb_ctrl import mem_pkg::*; (
    input  logic                  pclk,
    input  logic                  arst_n,
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    mem_pwr_if.ctrl               pwr
);

    logic       pwr_req;
    logic [1:0] state;
    logic       isol_q;
    logic       en_b_q;
    logic       rst_b_q;
    logic [1:0] chain_sync;
    logic       chain_out_s;
    logic       ack;
    logic [1:0] rst_rel;
    logic       ready;
    logic       access;
    logic       addr_ctrl;
    logic       addr_stat;

    // ----------------------------------------------------------------------
    // APB decode
    // ----------------------------------------------------------------------

    assign access    = psel && penable;
    assign addr_ctrl = (paddr == reg_pwr_ctrl);
    assign addr_stat = (paddr == reg_pwr_stat);

    // Zero wait state slave
    assign pready = 1'b1;

    // Unmapped addresses and writes to the read-only status are rejected
    assign pslverr = access && (!(addr_ctrl || addr_stat) || (pwrite && addr_stat));

    always_comb begin
        prdata = '0;
        if (access && !pwrite) begin
            if (addr_ctrl) begin
                prdata[0] = pwr_req;
            end else if (addr_stat) begin
                prdata[0] = !chain_out_s;
                prdata[1] = ready;
            end
        end
    end

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            pwr_req <= 1'b0;
        end else if (access && pwrite && addr_ctrl) begin
            pwr_req <= pwdata[0];
        end
    end

    // ----------------------------------------------------------------------
    // Power chain acknowledge
    // ----------------------------------------------------------------------

    // Chain output lives on rclk, bring it over with two flops
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            chain_sync <= 2'b11;
        end else begin
            chain_sync <= {chain_sync[0], pwr.pwr_enable_b_out};
        end
    end

    assign chain_out_s = chain_sync[1];
    // Acknowledged once the chain output has caught up with what we drive
    assign ack = (chain_out_s == en_b_q);

    // Mirrors the wrapper's reset synchronizer so ready means truly out of reset
    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            rst_rel <= 2'b00;
        end else begin
            rst_rel <= {rst_rel[0], rst_b_q};
        end
    end

    assign ready = (state == st_on) && !isol_q && rst_rel[1];

    // ----------------------------------------------------------------------
    // Sequencer
    // ----------------------------------------------------------------------

    always_ff @(posedge pclk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= st_off;
            isol_q  <= 1'b1;
            en_b_q  <= 1'b1;
            rst_b_q <= 1'b0;
        end else begin
            case (state)
                st_off: begin
                    if (pwr_req) begin
                        en_b_q <= 1'b0;
                        state  <= st_powering;
                    end
                end
                st_powering: begin
                    // A request dropped mid-way unwinds through power down
                    if (!pwr_req) begin
                        state <= st_powering_down;
                    end else if (ack) begin
                        isol_q <= 1'b0;
                        state  <= st_on;
                    end
                end
                st_on: begin
                    if (!pwr_req) begin
                        isol_q  <= 1'b1;
                        rst_b_q <= 1'b0;
                        state   <= st_powering_down;
                    end else begin
                        // Reset follows isolation release by one cycle
                        rst_b_q <= 1'b1;
                    end
                end
                st_powering_down: begin
                    // Enable goes off one cycle after the clamp is in place
                    if (!en_b_q) begin
                        en_b_q <= 1'b1;
                    end else if (ack) begin
                        state <= st_off;
                    end
                end
                default: begin
                    state <= st_off;
                end
            endcase
        end
    end

    assign pwr.pgcb_isol_en    = isol_q;
    assign pwr.pwr_enable_b_in = en_b_q;
    assign pwr.ip_reset_b      = rst_b_q;

    // Outputs may only be unclamped while the array reports full power
    a_isol_needs_ack : assert property (@(posedge pclk) disable iff (!arst_n)
        !isol_q |-> !chain_out_s)
        else $error("isolation released without power acknowledge");

endmodule

// File: logic/rf_pg_top.sv
/*
  Top level of the power-gated register file subsystem.
  Joins the APB power controller to the register file wrapper through
  the power bundle and exposes everything as plain ports.
*/
`timescale 1ns/1ps

module rf_pg_top import mem_pkg::*; (
    input  logic                  wclk,
    input  logic                  rclk,
    input  logic                  pclk,
    input  logic                  arst_n,
    // APB slave
    input  logic [apb_addr_w-1:0] paddr,
    input  logic                  psel,
    input  logic                  penable,
    input  logic                  pwrite,
    input  logic [apb_data_w-1:0] pwdata,
    output logic [apb_data_w-1:0] prdata,
    output logic                  pready,
    output logic                  pslverr,
    // Register file ports
    input  logic                  we,
    input  logic [rf_addr_w-1:0]  waddr,
    input  logic [rf_data_w-1:0]  wdata,
    input  logic                  re,
    input  logic [rf_addr_w-1:0]  raddr,
    output logic [rf_data_w-1:0]  rdata,
    // Scan controls
    input  logic                  fscan_byprst_b,
    input  logic                  fscan_clkungate,
    input  logic                  fscan_rstbypen
);

    mem_pwr_if pwr_if ();

    pgcb_apb_ctrl u_pgcb (
        .pclk    (pclk),
        .arst_n  (arst_n),
        .paddr   (paddr),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .pwr     (pwr_if.ctrl)
    );

    rf_pg_64x17 u_rf_pg (
        .wclk            (wclk),
        .we              (we),
        .waddr           (waddr),
        .wdata           (wdata),
        .rclk            (rclk),
        .re              (re),
        .raddr           (raddr),
        .rdata           (rdata),
        .pwr             (pwr_if.mem),
        .fscan_byprst_b  (fscan_byprst_b),
        .fscan_clkungate (fscan_clkungate),
        .fscan_rstbypen  (fscan_rstbypen)
    );

endmodule

// File: sim/tb_clkgen.sv
/*
  Testbench clock and reset source.
  One 20 ns clock feeds every clock pin of the DUT. Reset is held low
  for two cycles and released on a falling edge.
*/
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Release away from the rising edge so no flop sees a race
    initial begin
        arst_n = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

// File: sim/rf_pg_top_tb.sv
/*
  Table-driven testbench for the power-gated register file top level.
  The table is built at time zero next to a reference model of the array,
  then applied entry by entry with inputs driven on falling clock edges.
  A cycle watchdog bounds the run to 40 cycles per table entry.
*/
`timescale 1ns/1ps

module rf_pg_top_tb import mem_pkg::*; ();

    localparam int op_apb_wr    = 0;
    localparam int op_apb_rd    = 1;
    localparam int op_rf_wr     = 2;
    localparam int op_rf_rd     = 3;
    localparam int op_rf_rw     = 4;
    localparam int op_wait_stat = 5;
    localparam int op_scan      = 6;
    localparam int max_tests    = 128;

    logic                  clk;
    logic                  arst_n;
    logic [apb_addr_w-1:0] paddr;
    logic                  psel;
    logic                  penable;
    logic                  pwrite;
    logic [apb_data_w-1:0] pwdata;
    logic [apb_data_w-1:0] prdata;
    logic                  pready;
    logic                  pslverr;
    logic                  we;
    logic [rf_addr_w-1:0]  waddr;
    logic [rf_data_w-1:0]  wdata;
    logic                  re;
    logic [rf_addr_w-1:0]  raddr;
    logic [rf_data_w-1:0]  rdata;
    logic                  fscan_byprst_b;
    logic                  fscan_clkungate;
    logic                  fscan_rstbypen;

    // Stimulus table with one column per array
    int          tbl_op   [max_tests];
    logic [7:0]  tbl_addr [max_tests];
    logic [31:0] tbl_data [max_tests];
    logic [31:0] tbl_exp  [max_tests];
    logic        tbl_err  [max_tests];
    int          n_tests;

    // Reference model of the array contents and the read latch
    logic [rf_data_w-1:0] ref_mem [rf_depth];
    logic [rf_data_w-1:0] ref_rd;
    logic                 ref_on;
    logic                 ref_bypass;

    int   cycles;
    int   cycle_limit;
    int   n_fail;
    logic test_ok;

    tb_clkgen u_clkgen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    rf_pg_top uut (
        .wclk (clk), .rclk (clk), .pclk (clk), .arst_n (arst_n),
        .paddr (paddr), .psel (psel), .penable (penable), .pwrite (pwrite),
        .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
        .we (we), .waddr (waddr), .wdata (wdata),
        .re (re), .raddr (raddr), .rdata (rdata),
        .fscan_byprst_b (fscan_byprst_b), .fscan_clkungate (fscan_clkungate),
        .fscan_rstbypen (fscan_rstbypen)
    );

    // ----------------------------------------------------------------------
    // Table construction with the reference model
    // ----------------------------------------------------------------------

    task automatic add_entry(input int op, input int addr, input logic [31:0] data,
                             input logic [31:0] exp, input logic err);
        tbl_op[n_tests]   = op;
        tbl_addr[n_tests] = 8'(addr);
        tbl_data[n_tests] = data;
        tbl_exp[n_tests]  = exp;
        tbl_err[n_tests]  = err;
        n_tests++;
    endtask

    task automatic store_word(input logic [rf_addr_w-1:0] a, input logic [rf_data_w-1:0] d);
        ref_mem[a] = d;
        add_entry(op_rf_wr, int'(a), 32'(d), '0, 1'b0);
    endtask

    // Powered off reads see the clamp and a bypassed reset freezes the latch
    task automatic load_word(input logic [rf_addr_w-1:0] a);
        if (!ref_on) begin
            ref_rd = '0;
        end else if (!ref_bypass) begin
            ref_rd = ref_mem[a];
        end
        add_entry(op_rf_rd, int'(a), '0, 32'(ref_rd), 1'b0);
    endtask

    // Same edge write and read returns the word from before the write
    task automatic swap_word(input logic [rf_addr_w-1:0] a,
                             input logic [rf_data_w-1:0] d);
        ref_rd     = ref_mem[a];
        ref_mem[a] = d;
        add_entry(op_rf_rw, int'(a), 32'(d), 32'(ref_rd), 1'b0);
    endtask

    // Dropping the request loses every word and clears the latch
    task automatic set_power(input logic on);
        add_entry(op_apb_wr, int'(reg_pwr_ctrl), 32'(on), '0, 1'b0);
        if (!on) begin
            for (int i = 0; i < rf_depth; i++) begin
                ref_mem[i] = '0;
            end
            ref_rd = '0;
            ref_on = 1'b0;
        end
    endtask

    function automatic logic [rf_data_w-1:0] rand_word();
        logic [31:0] r;
        r = $urandom();
        return r[rf_data_w-1:0];
    endfunction

    task automatic build_table();
        n_tests    = 0;
        ref_rd     = '0;
        ref_on     = 1'b0;
        ref_bypass = 1'b0;
        for (int i = 0; i < rf_depth; i++) begin
            ref_mem[i] = '0;
        end
        // Register map and error responses straight out of reset
        add_entry(op_apb_rd, int'(reg_pwr_stat), '0, 32'd0, 1'b0);
        add_entry(op_apb_wr, int'(reg_pwr_stat), 32'd1, '0, 1'b1);
        add_entry(op_apb_rd, 'h08, '0, 32'd0, 1'b1);
        add_entry(op_apb_rd, int'(reg_pwr_ctrl), '0, 32'd0, 1'b0);
        // Power up and wait for ready
        set_power(1'b1);
        add_entry(op_apb_rd, int'(reg_pwr_ctrl), '0, 32'd1, 1'b0);
        add_entry(op_wait_stat, int'(reg_pwr_stat), '0, 32'd3, 1'b0);
        ref_on = 1'b1;
        // Random words spread over the address range
        for (int i = 0; i < 8; i++) begin
            store_word(6'(i * 7 + 3), rand_word());
        end
        for (int i = 0; i < 8; i++) begin
            load_word(6'(i * 7 + 3));
        end
        swap_word(6'd3, rand_word());
        load_word(6'd3);
        // Power cycle with reads while off and after the array is back
        set_power(1'b0);
        load_word(6'd3);
        add_entry(op_wait_stat, int'(reg_pwr_stat), '0, 32'd0, 1'b0);
        load_word(6'd10);
        set_power(1'b1);
        add_entry(op_wait_stat, int'(reg_pwr_stat), '0, 32'd3, 1'b0);
        ref_on = 1'b1;
        for (int i = 0; i < 8; i++) begin
            load_word(6'(i * 7 + 3));
        end
        // Scan bypass holds the array in reset so the latch keeps its word
        store_word(6'd5, 17'h1aaaa);
        store_word(6'd6, 17'h05555);
        load_word(6'd5);
        add_entry(op_scan, 0, 32'b10, '0, 1'b0);
        ref_bypass = 1'b1;
        load_word(6'd6);
        add_entry(op_scan, 0, 32'b01, '0, 1'b0);
        ref_bypass = 1'b0;
        load_word(6'd6);
    endtask

    // ----------------------------------------------------------------------
    // Bus drivers and checks
    // ----------------------------------------------------------------------

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp) else begin
            $display("ERR %0t: %s got %0h expected %0h", $time, what, got, exp);
            test_ok = 1'b0;
        end
    endtask

    // Setup then access phase with the sample taken mid low phase where prdata has settled
    task automatic apb_access(input logic [7:0] a, input logic wr, input logic [31:0] d,
                              output logic [31:0] rd, output logic err);
        @(negedge clk);
        paddr   = a;
        pwrite  = wr;
        pwdata  = d;
        psel    = 1'b1;
        penable = 1'b0;
        @(negedge clk);
        penable = 1'b1;
        #5;
        rd  = prdata;
        err = pslverr;
        check("pready", 32'(pready), 32'd1);
        @(negedge clk);
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    // One clock of the register file ports where rdata follows re by one cycle
    task automatic rf_cycle(input logic w, input logic r, input logic [7:0] a,
                            input logic [31:0] d, output logic [31:0] rd);
        @(negedge clk);
        we    = w;
        re    = r;
        waddr = a[rf_addr_w-1:0];
        raddr = a[rf_addr_w-1:0];
        wdata = d[rf_data_w-1:0];
        @(negedge clk);
        we = 1'b0;
        re = 1'b0;
        rd = 32'(rdata);
    endtask

    function automatic string op_name(input int op);
        case (op)
            op_apb_wr:    return "apb write";
            op_apb_rd:    return "apb read";
            op_rf_wr:     return "rf write";
            op_rf_rd:     return "rf read";
            op_rf_rw:     return "rf write+read";
            op_wait_stat: return "wait status";
            default:      return "scan bypass";
        endcase
    endfunction

    task automatic run_entry(input int i);
        logic [31:0] got;
        logic        err;
        case (tbl_op[i])
            op_apb_wr: begin
                apb_access(tbl_addr[i], 1'b1, tbl_data[i], got, err);
                check("pslverr", 32'(err), 32'(tbl_err[i]));
            end
            op_apb_rd: begin
                apb_access(tbl_addr[i], 1'b0, '0, got, err);
                check("prdata", got, tbl_exp[i]);
                check("pslverr", 32'(err), 32'(tbl_err[i]));
            end
            op_rf_wr: rf_cycle(1'b1, 1'b0, tbl_addr[i], tbl_data[i], got);
            op_rf_rd: begin
                rf_cycle(1'b0, 1'b1, tbl_addr[i], '0, got);
                check("rdata", got, tbl_exp[i]);
            end
            op_rf_rw: begin
                rf_cycle(1'b1, 1'b1, tbl_addr[i], tbl_data[i], got);
                check("rdata", got, tbl_exp[i]);
            end
            // Polls status until it matches while the watchdog bounds the wait
            op_wait_stat: begin
                do begin
                    apb_access(tbl_addr[i], 1'b0, '0, got, err);
                end while (got !== tbl_exp[i]);
            end
            default: begin
                @(negedge clk);
                fscan_rstbypen = tbl_data[i][1];
                fscan_byprst_b = tbl_data[i][0];
                @(negedge clk);
            end
        endcase
    endtask

    // ----------------------------------------------------------------------
    // Watchdog and main sequence
    // ----------------------------------------------------------------------

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        paddr           = '0;
        psel            = 1'b0;
        penable         = 1'b0;
        pwrite          = 1'b0;
        pwdata          = '0;
        we              = 1'b0;
        waddr           = '0;
        wdata           = '0;
        re              = 1'b0;
        raddr           = '0;
        fscan_byprst_b  = 1'b1;
        fscan_clkungate = 1'b0;
        fscan_rstbypen  = 1'b0;
        cycles          = 0;
        cycle_limit     = 0;
        n_fail          = 0;
        void'($urandom(4874));
        build_table();
        cycle_limit = n_tests * 40;
        @(posedge arst_n);
        for (int i = 0; i < n_tests; i++) begin
            test_ok = 1'b1;
            run_entry(i);
            if (!test_ok) begin
                n_fail++;
            end
            $display("test %0d %s addr %0h: %s", i, op_name(tbl_op[i]), tbl_addr[i],
                     test_ok ? "ok" : "FAIL");
        end
        $display("tests run %0d, passed %0d, failed %0d", n_tests, n_tests - n_fail, n_fail);
        if (n_fail == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: compile.f
logic/mem_pkg.sv
logic/mem_pwr_if.sv
logic/mem_reset_sync_scan.sv
logic/rf_array_64x18.sv
logic/rf_pg_64x17.sv
logic/pgcb_apb_ctrl.sv
logic/rf_pg_top.sv
sim/tb_clkgen.sv
sim/rf_pg_top_tb.sv

// File: Makefile
# Verilator build for the power-gated register file testbench

VERILATOR ?= verilator
TOP       ?= rf_pg_top_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Some tests failed" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
